/* dataPath.f */
design/dataPathPkg.sv
design/regSelectIf.sv
design/selectEncode.sv
design/registerFile.sv
design/specialRegisters.sv
design/arithmeticUnit.sv
design/memoryUnit.sv
design/conditionFlag.sv
design/busMux.sv
design/dataPath.sv
dv/dataPathTb.sv

/* runSim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module dataPathTb \
	-f dataPath.f -o VdataPathTb
./obj_dir/VdataPathTb > sim.log 2>&1
cat sim.log
if grep -q "tests failed" sim.log; then
	echo "simulation reported failures"
	exit 1
fi
echo "simulation clean"

/* dv/dataPathTb.sv */
`timescale 1ns/1ps

module dataPathTb import dataPathPkg::*; ();

	localparam int clockPeriod = 4;
	localparam int testCount = 6;
	localparam int seqCount = 200;
	// the memory store and load sequence is the longest, about 24 cycles
	localparam int cyclesPerSeq = 24;
	localparam int timeLimit = testCount * seqCount * cyclesPerSeq * clockPeriod * 2;

	logic clock;
	logic reset;
	logic pcIn, irIn, hiIn, loIn, yIn, zIn, marIn, mdrIn;
	logic outPortIn, inPortStrobe, conIn;
	logic pcOut, hiOut, loOut, zHighOut, zLowOut, mdrOut, inPortOut, cSignOut;
	logic gra, grb, grc, rIn, rOut, baOut, memRead, memWrite;
	aluOpT aluOp;
	logic [wordWidth-1:0] inputUnit;
	logic [wordWidth-1:0] outputUnit;
	logic conFlag;

	// reference model of the architectural state
	logic [wordWidth-1:0] modelRegs [regCount];
	logic [wordWidth-1:0] modelMem [ramDepth];

	integer seed;
	int errorCount;
	int passCount;
	int failCount;

	dataPath u_dut (.*);

	initial clock = 1'b0;
	always #(clockPeriod / 2) clock = ~clock;

	function automatic logic [wordWidth-1:0] randWord();
		return $random(seed);
	endfunction

	function automatic logic [3:0] randReg();
		logic [wordWidth-1:0] r;
		r = $random(seed);
		return r[3:0];
	endfunction

	// opcode left at zero, low holds rc, the constant or nothing
	function automatic logic [wordWidth-1:0] irFields(input logic [3:0] ra,
		input logic [3:0] rb, input logic [18:0] low);
		return {5'd0, ra, rb, low};
	endfunction

	function automatic logic [wordWidth-1:0] signExtend(input logic [18:0] c);
		return {{13{c[18]}}, c};
	endfunction

	function automatic logic [wordWidth-1:0] aluModel(input aluOpT op,
		input logic [wordWidth-1:0] y, input logic [wordWidth-1:0] b);
		case (op)
			aluAdd: return y + b;
			aluSub: return y - b;
			aluAnd: return y & b;
			aluOr: return y | b;
			default: return b + 32'd1;
		endcase
	endfunction

	function automatic logic condModel(input logic [1:0] cond, input logic [wordWidth-1:0] v);
		case (cond)
			2'd0: return v == 32'd0;
			2'd1: return v != 32'd0;
			2'd2: return ~v[31];
			default: return v[31];
		endcase
	endfunction

	task automatic clearControls();
		{pcIn, irIn, hiIn, loIn, yIn, zIn, marIn, mdrIn, outPortIn, inPortStrobe, conIn,
			pcOut, hiOut, loOut, zHighOut, zLowOut, mdrOut, inPortOut, cSignOut,
			gra, grb, grc, rIn, rOut, baOut, memRead, memWrite} = '0;
		aluOp = aluAdd;
	endtask

	// strobes set before this call last exactly one cycle
	task automatic step();
		@(posedge clock);
		#1;
		clearControls();
	endtask

	task automatic loadIr(input logic [wordWidth-1:0] value);
		inputUnit = value;
		inPortStrobe = 1'b1;
		step();
		inPortOut = 1'b1;
		irIn = 1'b1;
		step();
	endtask

	task automatic writeReg(input logic [3:0] idx, input logic [wordWidth-1:0] value);
		loadIr(irFields(idx, 4'd0, 19'd0));
		inputUnit = value;
		inPortStrobe = 1'b1;
		step();
		inPortOut = 1'b1;
		gra = 1'b1;
		rIn = 1'b1;
		step();
		modelRegs[idx] = value;
	endtask

	task automatic readToPort(input logic [3:0] idx, input logic ba);
		loadIr(irFields(idx, 4'd0, 19'd0));
		gra = 1'b1;
		rOut = ~ba;
		baOut = ba;
		outPortIn = 1'b1;
		step();
	endtask

	task automatic compareWord(input string what, input logic [wordWidth-1:0] expected,
		input logic [wordWidth-1:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %0t: %s, expected %h, got %h", $time, what, expected, actual);
			errorCount++;
		end
	endtask

	task automatic finishTest(input int number, input string name);
		if (errorCount == 0) begin
			passCount++;
			$display("test %0d %s: ok", number, name);
		end else begin
			failCount++;
			$display("test %0d %s: %0d mismatches", number, name, errorCount);
		end
		errorCount = 0;
	endtask

	task automatic testRoundTrip();
		logic [3:0] idx;
		for (int i = 0; i < seqCount; i++) begin
			idx = randReg();
			writeReg(idx, randWord());
			readToPort(idx, 1'b0);
			compareWord("register round trip", modelRegs[idx], outputUnit);
			if (i % 8 == 0) begin
				writeReg(4'd0, randWord());
				// base-address mode hides R0
				readToPort(4'd0, 1'b1);
				compareWord("R0 under baOut", '0, outputUnit);
			end
		end
		finishTest(1, "register round trip");
	endtask

	task automatic testAlu();
		logic [3:0] ra, rb, rc;
		logic [wordWidth-1:0] pick;
		logic [wordWidth-1:0] expected;
		aluOpT op;
		for (int i = 0; i < seqCount; i++) begin
			ra = randReg();
			rb = randReg();
			rc = randReg();
			pick = randWord() % 5;
			case (pick)
				0: op = aluAdd;
				1: op = aluSub;
				2: op = aluAnd;
				3: op = aluOr;
				default: op = aluInc;
			endcase
			writeReg(rb, randWord());
			writeReg(rc, randWord());
			expected = aluModel(op, modelRegs[rb], modelRegs[rc]);
			loadIr(irFields(ra, rb, {rc, 15'd0}));
			grb = 1'b1;
			rOut = 1'b1;
			yIn = 1'b1;
			step();
			grc = 1'b1;
			rOut = 1'b1;
			aluOp = op;
			zIn = 1'b1;
			step();
			zLowOut = 1'b1;
			gra = 1'b1;
			rIn = 1'b1;
			step();
			modelRegs[ra] = expected;
			readToPort(ra, 1'b0);
			compareWord("alu result", modelRegs[ra], outputUnit);
		end
		finishTest(2, "alu operations");
	endtask

	task automatic testMultiply();
		logic [3:0] rb, rc;
		logic [wordWidth-1:0] a, b;
		logic [2*wordWidth-1:0] product;
		for (int i = 0; i < seqCount; i++) begin
			rb = randReg();
			rc = randReg();
			writeReg(rb, randWord());
			writeReg(rc, randWord());
			a = modelRegs[rb];
			b = modelRegs[rc];
			product = {{32{a[31]}}, a} * {{32{b[31]}}, b};
			loadIr(irFields(4'd0, rb, {rc, 15'd0}));
			grb = 1'b1;
			rOut = 1'b1;
			yIn = 1'b1;
			step();
			grc = 1'b1;
			rOut = 1'b1;
			aluOp = aluMul;
			zIn = 1'b1;
			step();
			zHighOut = 1'b1;
			hiIn = 1'b1;
			step();
			zLowOut = 1'b1;
			loIn = 1'b1;
			step();
			hiOut = 1'b1;
			outPortIn = 1'b1;
			step();
			compareWord("product high word", product[63:32], outputUnit);
			loOut = 1'b1;
			outPortIn = 1'b1;
			step();
			compareWord("product low word", product[31:0], outputUnit);
		end
		finishTest(3, "multiply");
	endtask

	task automatic testMemory();
		logic [3:0] src, base, dest;
		logic baseIsR0;
		logic [wordWidth-1:0] r;
		logic [18:0] offset;
		logic [wordWidth-1:0] baseValue;
		logic [wordWidth-1:0] sum;
		logic [ramAddrWidth-1:0] addr;
		for (int i = 0; i < seqCount; i++) begin
			baseIsR0 = (i % 3 == 0);
			src = randReg();
			dest = randReg();
			base = baseIsR0 ? 4'd0 : randReg();
			r = randWord();
			offset = r[18:0];
			writeReg(base, randWord());
			writeReg(src, randWord());
			baseValue = baseIsR0 ? '0 : modelRegs[base];
			sum = baseValue + signExtend(offset);
			addr = sum[ramAddrWidth-1:0];
			loadIr(irFields(src, base, offset));
			// effective address goes through Y and Z into the MAR
			grb = 1'b1;
			rOut = ~baseIsR0;
			baOut = baseIsR0;
			yIn = 1'b1;
			step();
			cSignOut = 1'b1;
			aluOp = aluAdd;
			zIn = 1'b1;
			step();
			zLowOut = 1'b1;
			marIn = 1'b1;
			step();
			gra = 1'b1;
			rOut = 1'b1;
			mdrIn = 1'b1;
			step();
			mdrOut = 1'b1;
			memWrite = 1'b1;
			step();
			modelMem[addr] = modelRegs[src];
			// load back from the address the model worked out
			inputUnit = {{(wordWidth - ramAddrWidth){1'b0}}, addr};
			inPortStrobe = 1'b1;
			step();
			inPortOut = 1'b1;
			marIn = 1'b1;
			step();
			loadIr(irFields(dest, 4'd0, 19'd0));
			memRead = 1'b1;
			mdrIn = 1'b1;
			step();
			mdrOut = 1'b1;
			gra = 1'b1;
			rIn = 1'b1;
			step();
			modelRegs[dest] = modelMem[addr];
			readToPort(dest, 1'b0);
			compareWord("memory load", modelMem[addr], outputUnit);
		end
		finishTest(4, "memory");
	endtask

	task automatic testCondition();
		logic [3:0] idx;
		logic [1:0] cond;
		logic [wordWidth-1:0] value;
		for (int i = 0; i < seqCount; i++) begin
			idx = randReg();
			// zero needs to show up often enough
			value = (i % 4 == 0) ? '0 : randWord();
			writeReg(idx, value);
			for (int c = 0; c < 4; c++) begin
				cond = 2'(c);
				loadIr(irFields(idx, {2'b00, cond}, 19'd0));
				gra = 1'b1;
				rOut = 1'b1;
				conIn = 1'b1;
				step();
				compareWord("branch condition", {31'd0, condModel(cond, value)},
					{31'd0, conFlag});
			end
		end
		finishTest(5, "branch condition");
	endtask

	task automatic testConstant();
		logic [wordWidth-1:0] r;
		logic [18:0] c;
		for (int i = 0; i < seqCount; i++) begin
			r = randWord();
			c = r[18:0];
			loadIr(irFields(randReg(), randReg(), c));
			cSignOut = 1'b1;
			outPortIn = 1'b1;
			step();
			compareWord("constant path", signExtend(c), outputUnit);
		end
		finishTest(6, "constant path");
	endtask

	initial begin
		seed = 56902;
		errorCount = 0;
		passCount = 0;
		failCount = 0;
		inputUnit = '0;
		clearControls();
		reset = 1'b1;
		repeat (5) @(posedge clock);
		#1;
		reset = 1'b0;
		testRoundTrip();
		testAlu();
		testMultiply();
		testMemory();
		testCondition();
		testConstant();
		$display("summary: %0d of %0d tests clean, %0d with mismatches", passCount, testCount,
			failCount);
		if (failCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

	initial begin
		#(timeLimit);
		$display("watchdog: run stopped at %0t before all sequences completed", $time);
		$display("tests failed");
		$finish;
	end

endmodule

/* design/dataPath.sv */
`timescale 1ns/1ps

module dataPath import dataPathPkg::*; (
	input logic clock,
	input logic reset,
	input logic pcIn,
	input logic irIn,
	input logic hiIn,
	input logic loIn,
	input logic yIn,
	input logic zIn,
	input logic marIn,
	input logic mdrIn,
	input logic outPortIn,
	input logic inPortStrobe,
	input logic conIn,
	input logic pcOut,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic mdrOut,
	input logic inPortOut,
	input logic cSignOut,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	input logic baOut,
	input logic memRead,
	input logic memWrite,
	input aluOpT aluOp,
	input logic [wordWidth-1:0] inputUnit,
	output logic [wordWidth-1:0] outputUnit,
	output logic conFlag
);

	// the single shared bus
	logic [wordWidth-1:0] bus;
	logic [wordWidth-1:0] ir;
	logic [wordWidth-1:0] pc;
	logic [wordWidth-1:0] hi;
	logic [wordWidth-1:0] lo;
	logic [wordWidth-1:0] inPort;
	logic [wordWidth-1:0] zHigh;
	logic [wordWidth-1:0] zLow;
	logic [wordWidth-1:0] mdr;
	logic [wordWidth-1:0] regValue;

	regSelectIf regSel ();

	selectEncode u_selectEncode (
		.clock(clock),
		.reset(reset),
		.ir(ir),
		.gra(gra),
		.grb(grb),
		.grc(grc),
		.rIn(rIn),
		.rOut(rOut),
		.baOut(baOut),
		.sel(regSel.encoder)
	);

	registerFile u_registerFile (
		.clock(clock),
		.reset(reset),
		.bus(bus),
		.sel(regSel.registers),
		.readValue(regValue)
	);

	specialRegisters u_specialRegisters (
		.clock(clock),
		.reset(reset),
		.bus(bus),
		.pcIn(pcIn),
		.irIn(irIn),
		.hiIn(hiIn),
		.loIn(loIn),
		.outPortIn(outPortIn),
		.inPortStrobe(inPortStrobe),
		.inputUnit(inputUnit),
		.pc(pc),
		.ir(ir),
		.hi(hi),
		.lo(lo),
		.inPort(inPort),
		.outputUnit(outputUnit)
	);

	arithmeticUnit u_arithmeticUnit (
		.clock(clock),
		.reset(reset),
		.bus(bus),
		.yIn(yIn),
		.zIn(zIn),
		.aluOp(aluOp),
		.zHigh(zHigh),
		.zLow(zLow)
	);

	memoryUnit u_memoryUnit (
		.clock(clock),
		.reset(reset),
		.bus(bus),
		.marIn(marIn),
		.mdrIn(mdrIn),
		.memRead(memRead),
		.memWrite(memWrite),
		.mdr(mdr)
	);

	conditionFlag u_conditionFlag (
		.clock(clock),
		.reset(reset),
		.ir(ir),
		.bus(bus),
		.conIn(conIn),
		.conFlag(conFlag)
	);

	busMux u_busMux (
		.clock(clock),
		.reset(reset),
		.sel(regSel.bus),
		.regValue(regValue),
		.pc(pc),
		.hi(hi),
		.lo(lo),
		.zHigh(zHigh),
		.zLow(zLow),
		.mdr(mdr),
		.inPort(inPort),
		.pcOut(pcOut),
		.hiOut(hiOut),
		.loOut(loOut),
		.zHighOut(zHighOut),
		.zLowOut(zLowOut),
		.mdrOut(mdrOut),
		.inPortOut(inPortOut),
		.cSignOut(cSignOut),
		.bus(bus)
	);

endmodule

/* design/busMux.sv */
`timescale 1ns/1ps

module busMux import dataPathPkg::*; (
	input logic clock,
	input logic reset,
	regSelectIf.bus sel,
	input logic [wordWidth-1:0] regValue,
	input logic [wordWidth-1:0] pc,
	input logic [wordWidth-1:0] hi,
	input logic [wordWidth-1:0] lo,
	input logic [wordWidth-1:0] zHigh,
	input logic [wordWidth-1:0] zLow,
	input logic [wordWidth-1:0] mdr,
	input logic [wordWidth-1:0] inPort,
	input logic pcOut,
	input logic hiOut,
	input logic loOut,
	input logic zHighOut,
	input logic zLowOut,
	input logic mdrOut,
	input logic inPortOut,
	input logic cSignOut,
	output logic [wordWidth-1:0] bus
);

	// any regOut bit means the register file owns the bus
	always_comb begin
		bus = '0;
		if (|sel.regOut) bus = regValue;
		else if (pcOut) bus = pc;
		else if (hiOut) bus = hi;
		else if (loOut) bus = lo;
		else if (zHighOut) bus = zHigh;
		else if (zLowOut) bus = zLow;
		else if (mdrOut) bus = mdr;
		else if (inPortOut) bus = inPort;
		else if (cSignOut) bus = sel.constant;
	end

	singleDriver: assert property (@(posedge clock) disable iff (reset)
		$onehot0({sel.regOut, pcOut, hiOut, loOut, zHighOut, zLowOut, mdrOut, inPortOut,
			cSignOut}));

endmodule

/* design/conditionFlag.sv */
`timescale 1ns/1ps

module conditionFlag import dataPathPkg::*; (
	input logic clock,
	input logic reset,
	input logic [wordWidth-1:0] ir,
	input logic [wordWidth-1:0] bus,
	input logic conIn,
	output logic conFlag
);

	condT cond;
	logic met;

	assign cond = condT'(ir[condHi:condLo]);

	always_comb begin
		case (cond)
			condZero: met = (bus == '0);
			condNonZero: met = (bus != '0);
			condNonNeg: met = !bus[wordWidth-1];
			default: met = bus[wordWidth-1];
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) conFlag <= 1'b0;
		else if (conIn) conFlag <= met;
	end

endmodule

/* design/memoryUnit.sv */
`timescale 1ns/1ps

module memoryUnit import dataPathPkg::*; (
	input logic clock,
	input logic reset,
	input logic [wordWidth-1:0] bus,
	input logic marIn,
	input logic mdrIn,
	input logic memRead,
	input logic memWrite,
	output logic [wordWidth-1:0] mdr
);

	logic [ramAddrWidth-1:0] mar;
	logic [wordWidth-1:0] ram [ramDepth];
	logic [wordWidth-1:0] ramWord;

	// asynchronous read port
	assign ramWord = ram[mar];

	always_ff @(posedge clock) begin
		if (memWrite) begin
			ram[mar] <= bus;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			mar <= '0;
			mdr <= '0;
		end else begin
			if (marIn) mar <= bus[ramAddrWidth-1:0];
			// mdr input select, memory on a read, else the bus
			if (mdrIn) mdr <= memRead ? ramWord : bus;
		end
	end

	readWriteExclusive: assert property (@(posedge clock) disable iff (reset)
		!(memRead && memWrite));

endmodule

/* design/arithmeticUnit.sv */
`timescale 1ns/1ps

module arithmeticUnit import dataPathPkg::*; (
	input logic clock,
	input logic reset,
	input logic [wordWidth-1:0] bus,
	input logic yIn,
	input logic zIn,
	input aluOpT aluOp,
	output logic [wordWidth-1:0] zHigh,
	output logic [wordWidth-1:0] zLow
);

	logic [wordWidth-1:0] y;
	logic [wordWidth-1:0] narrow;
	logic signed [2*wordWidth-1:0] product;
	logic [2*wordWidth-1:0] aluResult;

	assign product = $signed(y) * $signed(bus);

	always_comb begin
		narrow = '0;
		case (aluOp)
			aluAdd: narrow = y + bus;
			aluSub: narrow = y - bus;
			aluAnd: narrow = y & bus;
			aluOr: narrow = y | bus;
			aluInc: narrow = bus + wordWidth'(1);
			default: narrow = '0;
		endcase
	end

	// only multiply fills the high word, the rest sign-extend
	assign aluResult = (aluOp == aluMul) ? product : {{wordWidth{narrow[wordWidth-1]}}, narrow};

	always_ff @(posedge clock) begin
		if (reset) begin
			y <= '0;
			zHigh <= '0;
			zLow <= '0;
		end else begin
			if (yIn) y <= bus;
			if (zIn) {zHigh, zLow} <= aluResult;
		end
	end

endmodule

/* design/specialRegisters.sv */
`timescale 1ns/1ps

module specialRegisters import dataPathPkg::*; (
	input logic clock,
	input logic reset,
	input logic [wordWidth-1:0] bus,
	input logic pcIn,
	input logic irIn,
	input logic hiIn,
	input logic loIn,
	input logic outPortIn,
	input logic inPortStrobe,
	input logic [wordWidth-1:0] inputUnit,
	output logic [wordWidth-1:0] pc,
	output logic [wordWidth-1:0] ir,
	output logic [wordWidth-1:0] hi,
	output logic [wordWidth-1:0] lo,
	output logic [wordWidth-1:0] inPort,
	output logic [wordWidth-1:0] outputUnit
);

	always_ff @(posedge clock) begin
		if (reset) begin
			pc <= '0;
			ir <= '0;
			hi <= '0;
			lo <= '0;
			inPort <= '0;
			outputUnit <= '0;
		end else begin
			if (pcIn) pc <= bus;
			if (irIn) ir <= bus;
			if (hiIn) hi <= bus;
			if (loIn) lo <= bus;
			// the input port samples the outside world, not the bus
			if (inPortStrobe) inPort <= inputUnit;
			if (outPortIn) outputUnit <= bus;
		end
	end

endmodule

/* design/registerFile.sv */
`timescale 1ns/1ps

module registerFile import dataPathPkg::*; (
	input logic clock,
	input logic reset,
	input logic [wordWidth-1:0] bus,
	regSelectIf.registers sel,
	output logic [wordWidth-1:0] readValue
);

	logic [wordWidth-1:0] regs [regCount];
	logic [wordWidth-1:0] r0Value;

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < regCount; i++) begin
				regs[i] <= '0;
			end
		end else begin
			for (int i = 0; i < regCount; i++) begin
				if (sel.regIn[i]) begin
					regs[i] <= bus;
				end
			end
		end
	end

	// base plus offset addressing treats R0 as zero
	assign r0Value = sel.baOut ? '0 : regs[0];

	always_comb begin
		readValue = '0;
		if (sel.regOut[0]) begin
			readValue = r0Value;
		end
		for (int i = 1; i < regCount; i++) begin
			if (sel.regOut[i]) begin
				readValue = regs[i];
			end
		end
	end

endmodule

/* design/selectEncode.sv */
`timescale 1ns/1ps

module selectEncode import dataPathPkg::*; (
	input logic clock,
	input logic reset,
	input logic [wordWidth-1:0] ir,
	input logic gra,
	input logic grb,
	input logic grc,
	input logic rIn,
	input logic rOut,
	input logic baOut,
	regSelectIf.encoder sel
);

	logic [regAddrWidth-1:0] regNum;
	logic [regCount-1:0] decoded;

	// pick the register field named by the field select
	always_comb begin
		regNum = '0;
		if (gra) begin
			regNum = ir[raHi:raLo];
		end else if (grb) begin
			regNum = ir[rbHi:rbLo];
		end else if (grc) begin
			regNum = ir[rcHi:rcLo];
		end
	end

	// no strobe at all when no field is selected
	assign decoded = (gra | grb | grc) ? (regCount'(1) << regNum) : '0;

	assign sel.regIn = decoded & {regCount{rIn}};
	assign sel.regOut = decoded & {regCount{rOut | baOut}};
	assign sel.baOut = baOut;
	assign sel.constant = {{(wordWidth - constWidth){ir[constHi]}}, ir[constHi:constLo]};

	fieldSelectOneHot: assert property (@(posedge clock) disable iff (reset)
		$onehot0({gra, grb, grc}));

endmodule

/* design/regSelectIf.sv */
`timescale 1ns/1ps

interface regSelectIf import dataPathPkg::*; ();

	// one-hot load and drive strobes for the general registers
	logic [regCount-1:0] regIn;
	logic [regCount-1:0] regOut;
	// base-address mode, R0 reads as zero
	logic baOut;
	logic [wordWidth-1:0] constant;

	modport encoder (output regIn, regOut, baOut, constant);

	modport registers (input regIn, regOut, baOut);

	modport bus (input regOut, constant);

endinterface

/* design/dataPathPkg.sv */
package dataPathPkg;

	localparam int wordWidth = 32;
	localparam int regCount = 16;
	localparam int regAddrWidth = 4;
	localparam int ramDepth = 512;
	localparam int ramAddrWidth = 9;

	// instruction register field positions
	localparam int opcodeHi = 31;
	localparam int opcodeLo = 27;
	localparam int raHi = 26;
	localparam int raLo = 23;
	localparam int rbHi = 22;
	localparam int rbLo = 19;
	localparam int rcHi = 18;
	localparam int rcLo = 15;
	localparam int constHi = 18;
	localparam int constLo = 0;
	localparam int constWidth = constHi - constLo + 1;
	localparam int condHi = 20;
	localparam int condLo = 19;

	// increment works on the bus value alone
	typedef enum logic [2:0] {aluAdd, aluSub, aluAnd, aluOr, aluMul, aluInc} aluOpT;

	typedef enum logic [1:0] {condZero, condNonZero, condNonNeg, condNeg} condT;

endpackage
